/* compile.f */
common/bridge_pkg.sv
rtl/ahb_slave/ahb_addr_phase.sv
rtl/ahb_slave/ahb_access_check.sv
rtl/ahb_slave/ahb_bridge_ctrl.sv
rtl/axi_cmd_buffer.sv
rtl/ahb_to_axi_bridge.sv
tb/bridge_properties.sv
tb/tb_ahb_to_axi.sv

/* Makefile */
# Verilator build and run of the AHB to AXI bridge testbench

VERILATOR ?= verilator
TOP       ?= tb_ahb_to_axi
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

# Build, run and look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_ahb_to_axi.sv */
// Testbench for the AHB-Lite to AXI4 bridge
// AHB master tasks, AXI slave memory with random stalls,
// reference rules for access errors and strobes, and AXI channel checkers

module tb_ahb_to_axi;
  import bridge_pkg::*;

  localparam int          ADDR_WIDTH  = 32;
  localparam logic [31:0] DCCM_BASE   = 32'h2000_0000;
  localparam logic [31:0] ICCM_BASE   = 32'h1000_0000;
  localparam int          WINDOW_BITS = 16;
  // Doubleword that the slave answers with SLVERR
  localparam logic [31:0] ERR_ADDR    = DCCM_BASE + 32'h100;
  // Transfers per test: basic, strobes, errors, slave error, random writes
  localparam int          N_XFERS     = 8 + 5 + 5 + 1 + 20;
  localparam int          TIMEOUT     = N_XFERS * 40 + 100;

  logic                  bus_clk = 1'b0;
  logic                  rst_l   = 1'b1;
  logic                  hsel;
  logic [ADDR_WIDTH-1:0] haddr;
  logic                  hwrite;
  hsize_t                hsize;
  htrans_t               htrans;
  logic [DATA_W-1:0]     hwdata;
  logic [DATA_W-1:0]     hrdata;
  logic                  hreadyout;
  logic                  hresp;
  logic                  axi_aw_valid;
  logic                  axi_aw_ready;
  logic [ADDR_WIDTH-1:0] axi_aw_addr;
  hsize_t                axi_aw_size;
  logic [DATA_W-1:0]     axi_w_data;
  logic [STRB_W-1:0]     axi_w_strb;
  logic                  axi_ar_valid;
  logic                  axi_ar_ready;
  logic [ADDR_WIDTH-1:0] axi_ar_addr;
  hsize_t                axi_ar_size;
  logic                  axi_r_valid;
  logic [DATA_W-1:0]     axi_r_data;
  logic [RESP_W-1:0]     axi_r_resp;

  // Slave memory and reference memory, one entry per doubleword
  logic [63:0] mem [logic [28:0]];
  logic [63:0] ref_mem [logic [28:0]];
  // AXI writes the bridge still owes, oldest first
  logic [31:0] exp_addr_q [$];
  logic [63:0] exp_data_q [$];
  logic [7:0]  exp_strb_q [$];
  hsize_t      exp_size_q [$];
  // Read the bridge is expected to issue next
  logic [31:0] rd_exp_addr     = '0;
  hsize_t      rd_exp_size     = SZ_DWORD;
  int          err_count       = 0;
  int          check_count     = 0;
  int          ar_valid_cycles = 0;
  int          cycles          = 0;

  always #20 bus_clk = ~bus_clk;

  ahb_to_axi_bridge #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DCCM_BASE   (DCCM_BASE),
    .ICCM_BASE   (ICCM_BASE),
    .WINDOW_BITS (WINDOW_BITS)
  ) i_ahb_to_axi_bridge (.*);

  //////////////////////////////
  // Reference rules
  //////////////////////////////

  // Untouched memory content, unique per doubleword
  function automatic logic [63:0] fill_word(logic [31:0] addr);
    return {addr[31:3], 3'b000, ~addr[31:3], 3'b111};
  endfunction

  // Window, size and alignment rule
  function automatic bit expect_error(logic [31:0] addr, hsize_t size, logic wr);
    bit dccm;
    bit iccm;
    bit narrow;
    bit misalign;
    dccm     = (addr >> WINDOW_BITS) == (DCCM_BASE >> WINDOW_BITS);
    iccm     = (addr >> WINDOW_BITS) == (ICCM_BASE >> WINDOW_BITS);
    narrow   = size < SZ_WORD;
    misalign = (addr % (32'd1 << size)) != 0;
    return !(dccm || iccm) || (narrow && (iccm || (dccm && wr))) || misalign;
  endfunction

  // Lanes from the start byte up to the transfer size
  function automatic logic [7:0] expect_strb(logic [31:0] addr, hsize_t size);
    logic [7:0] strb;
    int         first;
    int         nbytes;
    int         i;
    first  = int'(addr[2:0]);
    nbytes = 1 << size;
    for (i = 0; i < 8; i++) begin
      strb[i] = (i >= first) && (i < first + nbytes);
    end
    return strb;
  endfunction

  function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
                                              logic [7:0] strb);
    logic [63:0] res;
    int          i;
    res = old;
    for (i = 0; i < 8; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [63:0] ref_read(logic [31:0] addr);
    if (ref_mem.exists(addr[31:3])) begin
      return ref_mem[addr[31:3]];
    end
    return fill_word(addr);
  endfunction

  task automatic check_equal(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    check_count++;
    if (expected !== actual) begin
      err_count++;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end
  endtask

  //////////////////////////////
  // AHB master
  //////////////////////////////

  // Address phase, then one data phase with no pipelined address
  task automatic run_transfer(input logic [31:0] addr, input logic wr, input hsize_t size,
                              input logic [63:0] wdata, output logic [63:0] rdata,
                              output logic err);
    logic first_err;
    hsel   <= 1'b1;
    haddr  <= addr;
    hwrite <= wr;
    hsize  <= size;
    htrans <= TR_NONSEQ;
    @(negedge bus_clk);
    while (!hreadyout) begin
      @(negedge bus_clk);
    end
    @(posedge bus_clk);
    htrans <= TR_IDLE;
    if (wr) begin
      hwdata <= wdata;
    end
    // Error needs hresp with hreadyout low, then both high
    first_err = 1'b0;
    @(negedge bus_clk);
    while (!hreadyout) begin
      first_err = first_err | hresp;
      @(negedge bus_clk);
    end
    err   = first_err & hresp;
    rdata = hrdata;
    @(posedge bus_clk);
  endtask

  task automatic write_access(input string name, input logic [31:0] addr, input hsize_t size,
                              input logic [63:0] data);
    logic [63:0] rdata;
    logic        err;
    logic        exp_err;
    logic [7:0]  strb;
    exp_err = expect_error(addr, size, 1'b1);
    strb    = expect_strb(addr, size);
    // Legal writes must show up on AXI in this order
    if (!exp_err) begin
      exp_addr_q.push_back(addr);
      exp_data_q.push_back(data);
      exp_strb_q.push_back(strb);
      exp_size_q.push_back(size);
      ref_mem[addr[31:3]] = merge_bytes(ref_read(addr), data, strb);
    end
    run_transfer(addr, 1'b1, size, data, rdata, err);
    check_equal({name, " hresp"}, 64'(exp_err), 64'(err));
  endtask

  task automatic read_access(input string name, input logic [31:0] addr, input hsize_t size);
    logic [63:0] rdata;
    logic        err;
    logic        exp_err;
    logic        rule_err;
    int          ar_before;
    rule_err    = expect_error(addr, size, 1'b0);
    exp_err     = rule_err || (addr[31:3] == ERR_ADDR[31:3]);
    ar_before   = ar_valid_cycles;
    rd_exp_addr = addr;
    rd_exp_size = size;
    run_transfer(addr, 1'b0, size, 64'h0, rdata, err);
    check_equal({name, " hresp"}, 64'(exp_err), 64'(err));
    if (!exp_err) begin
      check_equal({name, " data"}, ref_read(addr), rdata);
    end
    // Rejected reads never reach AXI
    if (rule_err) begin
      check_equal({name, " ar valid"}, 64'(ar_before), 64'(ar_valid_cycles));
    end
  endtask

  //////////////////////////////
  // AXI slave and checker
  //////////////////////////////

  // One command at a time, random 0 to 3 cycle stalls
  initial begin : axi_slave
    int unsigned delay;
    logic [28:0] idx;
    forever begin
      @(negedge bus_clk);
      if (rst_l && axi_aw_valid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge bus_clk);
        @(posedge bus_clk);
        axi_aw_ready <= 1'b1;
        @(negedge bus_clk);
        idx = axi_aw_addr[31:3];
        if (!mem.exists(idx)) begin
          mem[idx] = fill_word(axi_aw_addr);
        end
        mem[idx] = merge_bytes(mem[idx], axi_w_data, axi_w_strb);
        @(posedge bus_clk);
        axi_aw_ready <= 1'b0;
      end else if (rst_l && axi_ar_valid) begin
        delay = $urandom_range(3, 0);
        repeat (delay) @(negedge bus_clk);
        @(posedge bus_clk);
        axi_ar_ready <= 1'b1;
        @(negedge bus_clk);
        idx = axi_ar_addr[31:3];
        @(posedge bus_clk);
        axi_ar_ready <= 1'b0;
        delay = $urandom_range(3, 0);
        repeat (delay) @(posedge bus_clk);
        axi_r_valid <= 1'b1;
        axi_r_data  <= mem.exists(idx) ? mem[idx] : fill_word(axi_ar_addr);
        axi_r_resp  <= (idx == ERR_ADDR[31:3]) ? 2'b10 : 2'b00;
        @(posedge bus_clk);
        axi_r_valid <= 1'b0;
        axi_r_resp  <= 2'b00;
      end
    end
  end

  // Compare each AXI write with the oldest one owed
  always @(negedge bus_clk) begin
    if (rst_l && axi_aw_valid && axi_aw_ready) begin
      if (exp_addr_q.size() == 0) begin
        err_count++;
        $display("Unexpected AXI write to address %h", axi_aw_addr);
      end else begin
        check_equal("aw addr", 64'(exp_addr_q.pop_front()), 64'(axi_aw_addr));
        check_equal("aw size", 64'(exp_size_q.pop_front()), 64'(axi_aw_size));
        check_equal("w data", exp_data_q.pop_front(), axi_w_data);
        check_equal("w strb", 64'(exp_strb_q.pop_front()), 64'(axi_w_strb));
      end
    end
  end

  // Count read address valid cycles, compare the read on its handshake
  always @(negedge bus_clk) begin
    if (rst_l && axi_ar_valid) begin
      ar_valid_cycles++;
      if (axi_ar_ready) begin
        check_equal("ar addr", 64'(rd_exp_addr), 64'(axi_ar_addr));
        check_equal("ar size", 64'(rd_exp_size), 64'(axi_ar_size));
      end
    end
  end

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("Timeout after %0d cycles, a transfer never completed", TIMEOUT);
      $display("Checks %0d, errors %0d", check_count, err_count + 1);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : main
    logic [31:0] addr;
    hsize_t      size;
    int          i;
    void'($urandom(32'ha0ce));
    rst_l        <= 1'b0;
    hsel         <= 1'b0;
    haddr        <= '0;
    hwrite       <= 1'b0;
    hsize        <= SZ_DWORD;
    htrans       <= TR_IDLE;
    hwdata       <= '0;
    axi_aw_ready <= 1'b0;
    axi_ar_ready <= 1'b0;
    axi_r_valid  <= 1'b0;
    axi_r_data   <= '0;
    axi_r_resp   <= '0;
    repeat (3) @(posedge bus_clk);
    rst_l <= 1'b1;

    // Idle bus after reset
    @(negedge bus_clk);
    check_equal("reset hreadyout", 64'(1'b1), 64'(hreadyout));
    check_equal("reset hresp", 64'(1'b0), 64'(hresp));
    check_equal("reset aw valid", 64'(1'b0), 64'(axi_aw_valid));
    check_equal("reset ar valid", 64'(1'b0), 64'(axi_ar_valid));
    @(posedge bus_clk);

    // Doublewords in both windows
    for (i = 0; i < 4; i++) begin
      addr = (i < 2 ? DCCM_BASE : ICCM_BASE) + 32'h40 * i;
      write_access("dword write", addr, SZ_DWORD, {$urandom, $urandom});
    end
    for (i = 0; i < 4; i++) begin
      addr = (i < 2 ? DCCM_BASE : ICCM_BASE) + 32'h40 * i;
      read_access("dword read", addr, SZ_DWORD);
    end

    // Narrow DCCM writes, only the word reaches memory
    addr = DCCM_BASE + 32'h80;
    write_access("strobe base", addr, SZ_DWORD, {$urandom, $urandom});
    write_access("byte write", addr + 32'h1, SZ_BYTE, {$urandom, $urandom});
    write_access("half write", addr + 32'h2, SZ_HALF, {$urandom, $urandom});
    write_access("word write", addr + 32'h4, SZ_WORD, {$urandom, $urandom});
    read_access("strobe readback", addr, SZ_DWORD);

    // Illegal reads
    read_access("misaligned half", DCCM_BASE + 32'h1, SZ_HALF);
    read_access("misaligned word", DCCM_BASE + 32'h2, SZ_WORD);
    read_access("misaligned dword", ICCM_BASE + 32'h4, SZ_DWORD);
    read_access("out of window", 32'h3000_0000, SZ_DWORD);
    read_access("narrow iccm", ICCM_BASE + 32'h8, SZ_BYTE);

    read_access("slave error", ERR_ADDR, SZ_DWORD);

    // Writes back to back over four doublewords
    for (i = 0; i < 16; i++) begin
      addr = DCCM_BASE + 32'h200 + (32'($urandom_range(7, 0)) << 2);
      size = (addr[2] || $urandom_range(1, 0) == 1) ? SZ_WORD : SZ_DWORD;
      write_access("burst write", addr, size, {$urandom, $urandom});
    end
    for (i = 0; i < 4; i++) begin
      read_access("burst readback", DCCM_BASE + 32'h200 + 32'h8 * i, SZ_DWORD);
    end

    if (exp_addr_q.size() != 0) begin
      err_count++;
      $display("%0d expected AXI writes never appeared", exp_addr_q.size());
    end
    $display("Checks %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* tb/bridge_properties.sv */
// Bridge protocol assertions
// Bound into the top level, checks AXI valid stability,
// channel exclusion and AHB error and reset timing

module bridge_properties #(
  parameter int ADDR_WIDTH = 32
) (
  input logic                          bus_clk,
  input logic                          rst_l,
  input logic                          hreadyout,
  input logic                          hresp,
  input logic                          axi_aw_valid,
  input logic                          axi_aw_ready,
  input logic [ADDR_WIDTH-1:0]         axi_aw_addr,
  input bridge_pkg::hsize_t            axi_aw_size,
  input logic [bridge_pkg::DATA_W-1:0] axi_w_data,
  input logic [bridge_pkg::STRB_W-1:0] axi_w_strb,
  input logic                          axi_ar_valid,
  input logic                          axi_ar_ready,
  input logic [ADDR_WIDTH-1:0]         axi_ar_addr,
  input bridge_pkg::hsize_t            axi_ar_size
);
  import bridge_pkg::*;

  //////////////////////////////
  // AXI side
  //////////////////////////////

  // Write address and data held until accepted
  aw_hold: assert property (@(posedge bus_clk) disable iff (!rst_l)
    axi_aw_valid && !axi_aw_ready |=> axi_aw_valid && $stable(axi_aw_addr) &&
      $stable(axi_aw_size) && $stable(axi_w_data) && $stable(axi_w_strb))
    else $error("aw channel dropped or changed before ready");

  ar_hold: assert property (@(posedge bus_clk) disable iff (!rst_l)
    axi_ar_valid && !axi_ar_ready |=> axi_ar_valid && $stable(axi_ar_addr) &&
      $stable(axi_ar_size))
    else $error("ar channel dropped or changed before ready");

  // One entry, so never both channels
  one_channel: assert property (@(posedge bus_clk) disable iff (!rst_l)
    !(axi_aw_valid && axi_ar_valid))
    else $error("aw and ar valid together");

  //////////////////////////////
  // AHB side
  //////////////////////////////

  err_first: assert property (@(posedge bus_clk) disable iff (!rst_l)
    $rose(hresp) |-> !hreadyout)
    else $error("first error cycle with hreadyout high");

  reset_ready: assert property (@(posedge bus_clk)
    $rose(rst_l) |-> hreadyout)
    else $error("hreadyout low after reset release");

endmodule

bind ahb_to_axi_bridge bridge_properties #(
  .ADDR_WIDTH (ADDR_WIDTH)
) i_bridge_properties (
  .bus_clk      (bus_clk),
  .rst_l        (rst_l),
  .hreadyout    (hreadyout),
  .hresp        (hresp),
  .axi_aw_valid (axi_aw_valid),
  .axi_aw_ready (axi_aw_ready),
  .axi_aw_addr  (axi_aw_addr),
  .axi_aw_size  (axi_aw_size),
  .axi_w_data   (axi_w_data),
  .axi_w_strb   (axi_w_strb),
  .axi_ar_valid (axi_ar_valid),
  .axi_ar_ready (axi_ar_ready),
  .axi_ar_addr  (axi_ar_addr),
  .axi_ar_size  (axi_ar_size)
);

/* rtl/ahb_to_axi_bridge.sv */
// AHB-Lite slave to AXI4 master bridge, top level
// Connects address capture, access check and controller
// on the AHB side to the single-entry AXI command buffer

module ahb_to_axi_bridge #(
  parameter int                    ADDR_WIDTH  = 32,
  parameter logic [ADDR_WIDTH-1:0] DCCM_BASE   = 32'h2000_0000,
  parameter logic [ADDR_WIDTH-1:0] ICCM_BASE   = 32'h1000_0000,
  parameter int                    WINDOW_BITS = 16
) (
  input  logic                          bus_clk,
  input  logic                          rst_l,

  // AHB-Lite slave
  input  logic                          hsel,
  input  logic [ADDR_WIDTH-1:0]         haddr,
  input  logic                          hwrite,
  input  bridge_pkg::hsize_t            hsize,
  input  bridge_pkg::htrans_t           htrans,
  input  logic [bridge_pkg::DATA_W-1:0] hwdata,
  output logic [bridge_pkg::DATA_W-1:0] hrdata,
  output logic                          hreadyout,
  output logic                          hresp,

  // AXI4 write address and data
  output logic                          axi_aw_valid,
  input  logic                          axi_aw_ready,
  output logic [ADDR_WIDTH-1:0]         axi_aw_addr,
  output bridge_pkg::hsize_t            axi_aw_size,
  output logic [bridge_pkg::DATA_W-1:0] axi_w_data,
  output logic [bridge_pkg::STRB_W-1:0] axi_w_strb,

  // AXI4 read address
  output logic                          axi_ar_valid,
  input  logic                          axi_ar_ready,
  output logic [ADDR_WIDTH-1:0]         axi_ar_addr,
  output bridge_pkg::hsize_t            axi_ar_size,

  // AXI4 read data, always accepted
  input  logic                          axi_r_valid,
  input  logic [bridge_pkg::DATA_W-1:0] axi_r_data,
  input  logic [bridge_pkg::RESP_W-1:0] axi_r_resp
);
  import bridge_pkg::*;

  // Captured address phase
  logic [ADDR_WIDTH-1:0] addr_q;
  hsize_t                size_q;
  logic                  write_q;
  htrans_t               trans_q;
  logic                  hready_q;
  logic                  hresp_q;
  logic [STRB_W-1:0]     wstrb;

  // Controller and buffer handshake
  logic                  access_err;
  logic                  cmd_load;
  logic                  cmd_full;
  logic                  cmd_write;

  ahb_addr_phase #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_ahb_addr_phase (
    .bus_clk   (bus_clk),
    .rst_l     (rst_l),
    .hsel      (hsel),
    .haddr     (haddr),
    .hwrite    (hwrite),
    .hsize     (hsize),
    .htrans    (htrans),
    .hreadyout (hreadyout),
    .hresp     (hresp),
    .addr_q    (addr_q),
    .size_q    (size_q),
    .write_q   (write_q),
    .trans_q   (trans_q),
    .hready_q  (hready_q),
    .hresp_q   (hresp_q),
    .wstrb     (wstrb)
  );

  ahb_access_check #(
    .ADDR_WIDTH  (ADDR_WIDTH),
    .DCCM_BASE   (DCCM_BASE),
    .ICCM_BASE   (ICCM_BASE),
    .WINDOW_BITS (WINDOW_BITS)
  ) i_ahb_access_check (
    .addr_q     (addr_q),
    .size_q     (size_q),
    .write_q    (write_q),
    .access_err (access_err)
  );

  ahb_bridge_ctrl i_ahb_bridge_ctrl (
    .bus_clk     (bus_clk),
    .rst_l       (rst_l),
    .hsel        (hsel),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .trans_q     (trans_q),
    .hready_q    (hready_q),
    .hresp_q     (hresp_q),
    .access_err  (access_err),
    .cmd_full    (cmd_full),
    .cmd_write   (cmd_write),
    .axi_r_valid (axi_r_valid),
    .axi_r_data  (axi_r_data),
    .axi_r_resp  (axi_r_resp),
    .cmd_load    (cmd_load),
    .hreadyout   (hreadyout),
    .hresp       (hresp),
    .hrdata      (hrdata)
  );

  axi_cmd_buffer #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) i_axi_cmd_buffer (
    .bus_clk      (bus_clk),
    .rst_l        (rst_l),
    .cmd_load     (cmd_load),
    .hresp        (hresp),
    .addr_q       (addr_q),
    .size_q       (size_q),
    .write_q      (write_q),
    .wstrb        (wstrb),
    .hwdata       (hwdata),
    .axi_aw_ready (axi_aw_ready),
    .axi_ar_ready (axi_ar_ready),
    .cmd_full     (cmd_full),
    .cmd_write    (cmd_write),
    .axi_aw_valid (axi_aw_valid),
    .axi_aw_addr  (axi_aw_addr),
    .axi_aw_size  (axi_aw_size),
    .axi_w_data   (axi_w_data),
    .axi_w_strb   (axi_w_strb),
    .axi_ar_valid (axi_ar_valid),
    .axi_ar_addr  (axi_ar_addr),
    .axi_ar_size  (axi_ar_size)
  );

endmodule

/* rtl/axi_cmd_buffer.sv */
// AXI command buffer
// One-entry holding register for a checked AHB transfer, presented as
// a single-beat write on aw/w or a single-beat read on ar

module axi_cmd_buffer #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                          bus_clk,
  input  logic                          rst_l,
  input  logic                          cmd_load,
  input  logic                          hresp,
  input  logic [ADDR_WIDTH-1:0]         addr_q,
  input  bridge_pkg::hsize_t            size_q,
  input  logic                          write_q,
  input  logic [bridge_pkg::STRB_W-1:0] wstrb,
  input  logic [bridge_pkg::DATA_W-1:0] hwdata,
  input  logic                          axi_aw_ready,
  input  logic                          axi_ar_ready,
  output logic                          cmd_full,
  output logic                          cmd_write,
  output logic                          axi_aw_valid,
  output logic [ADDR_WIDTH-1:0]         axi_aw_addr,
  output bridge_pkg::hsize_t            axi_aw_size,
  output logic [bridge_pkg::DATA_W-1:0] axi_w_data,
  output logic [bridge_pkg::STRB_W-1:0] axi_w_strb,
  output logic                          axi_ar_valid,
  output logic [ADDR_WIDTH-1:0]         axi_ar_addr,
  output bridge_pkg::hsize_t            axi_ar_size
);
  import bridge_pkg::*;

  logic                  cmd_vld;
  logic                  cmd_done;
  logic                  cmd_clr;
  hsize_t                cmd_size;
  logic [STRB_W-1:0]     cmd_strb;
  logic [ADDR_WIDTH-1:0] cmd_addr;
  logic [DATA_W-1:0]     cmd_data;

  // Either address channel handshake retires the entry
  assign cmd_done = (axi_aw_valid & axi_aw_ready) | (axi_ar_valid & axi_ar_ready);

  // Keep the entry when a new load lands on the handshake edge
  // a read that is still waiting is dropped on an AHB error
  assign cmd_clr  = (cmd_done & ~cmd_load) | (hresp & ~cmd_write);

  // Free as soon as the handshake is seen
  assign cmd_full = cmd_vld & ~cmd_done;

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      cmd_vld   <= 1'b0;
      cmd_write <= 1'b0;
    end else begin
      cmd_vld <= ~cmd_clr & (cmd_load | cmd_vld);
      if (cmd_load) begin
        cmd_write <= write_q;
      end
    end
  end

  // Command payload
  // hwdata is valid in the data phase, same cycle as cmd_load
  always_ff @(posedge bus_clk) begin
    if (cmd_load) begin
      cmd_size <= size_q;
      cmd_strb <= wstrb;
      cmd_addr <= addr_q;
      cmd_data <= hwdata;
    end
  end

  //////////////////////////////
  // AXI channels
  //////////////////////////////

  // Write data travels with the address under one valid
  assign axi_aw_valid = cmd_vld & cmd_write;
  assign axi_aw_addr  = cmd_addr;
  assign axi_aw_size  = cmd_size;
  assign axi_w_data   = cmd_data;
  assign axi_w_strb   = cmd_strb;

  assign axi_ar_valid = cmd_vld & ~cmd_write;
  assign axi_ar_addr  = cmd_addr;
  assign axi_ar_size  = cmd_size;

endmodule

/* rtl/ahb_slave/ahb_bridge_ctrl.sv */
// Bridge controller
// Four-state FSM that sequences AHB data phases against the command
// buffer, drives hreadyout and hresp, and holds returned read data

module ahb_bridge_ctrl (
  input  logic                          bus_clk,
  input  logic                          rst_l,
  input  logic                          hsel,
  input  bridge_pkg::htrans_t           htrans,
  input  logic                          hwrite,
  input  bridge_pkg::htrans_t           trans_q,
  input  logic                          hready_q,
  input  logic                          hresp_q,
  input  logic                          access_err,
  input  logic                          cmd_full,
  input  logic                          cmd_write,
  input  logic                          axi_r_valid,
  input  logic [bridge_pkg::DATA_W-1:0] axi_r_data,
  input  logic [bridge_pkg::RESP_W-1:0] axi_r_resp,
  output logic                          cmd_load,
  output logic                          hreadyout,
  output logic                          hresp,
  output logic [bridge_pkg::DATA_W-1:0] hrdata
);
  import bridge_pkg::*;

  bridge_state_t       state;
  bridge_state_t       state_nxt;
  logic                state_en;
  logic                rdata_en;
  logic                read_err_in;
  logic                read_err;
  logic [DATA_W-1:0]   rdata_q;
  logic                active;

  //////////////////////////////
  // State machine
  //////////////////////////////

  always_comb begin
    state_nxt   = ST_IDLE;
    state_en    = 1'b0;
    rdata_en    = 1'b0;
    read_err_in = 1'b0;
    cmd_load    = 1'b0;
    case (state)
      ST_IDLE: begin
        // Leave only on an accepted transfer
        state_nxt = hwrite ? ST_WR : ST_RD;
        state_en  = hreadyout & hsel & (htrans == TR_NONSEQ || htrans == TR_SEQ);
      end
      ST_WR: begin
        // Follow the next address phase, or drop back on error or idle
        state_nxt = (hresp | (htrans == TR_IDLE) | ~hsel) ? ST_IDLE :
                    (hwrite ? ST_WR : ST_RD);
        state_en  = ~cmd_full | hresp;
        // Hold off the load on error or while the master is busy
        cmd_load  = ~cmd_full & ~(hresp | ((htrans == TR_BUSY) & hsel));
      end
      ST_RD: begin
        state_nxt = hresp ? ST_IDLE : ST_PEND;
        state_en  = ~cmd_full | hresp;
        cmd_load  = ~cmd_full & ~hresp;
      end
      ST_PEND: begin
        // Data is presented the cycle after it lands
        state_nxt   = ST_IDLE;
        state_en    = axi_r_valid & ~cmd_write;
        rdata_en    = state_en;
        read_err_in = state_en & (|axi_r_resp);
      end
      default: begin
        state_nxt = ST_IDLE;
        state_en  = 1'b1;
      end
    endcase
  end

  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      state <= ST_IDLE;
    end else if (state_en) begin
      state <= state_nxt;
    end
  end

  //////////////////////////////
  // AHB response
  //////////////////////////////

  // Transfer still in its data phase
  assign active = (trans_q != TR_IDLE) & (state != ST_IDLE);

  // Error sources, second cycle comes from the registered copy
  assign hresp = (active & access_err) | read_err | (hresp_q & ~hready_q);

  // First error cycle low, second high
  // otherwise wait on a full buffer or an outstanding read
  assign hreadyout = hresp ? (hresp_q & ~hready_q) :
                     ((~cmd_full | (state == ST_IDLE)) &
                      ~(state == ST_RD || state == ST_PEND) & ~read_err);

  //////////////////////////////
  // Read return
  //////////////////////////////

  always_ff @(posedge bus_clk) begin
    if (rdata_en) begin
      rdata_q <= axi_r_data;
    end
  end

  // Pulses for a single cycle to start the error response
  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      read_err <= 1'b0;
    end else begin
      read_err <= read_err_in;
    end
  end

  assign hrdata = rdata_q;

endmodule

/* rtl/ahb_slave/ahb_access_check.sv */
// AHB access check
// Decodes the DCCM and ICCM windows for the captured address
// and flags illegal window, size or alignment combinations

module ahb_access_check #(
  parameter int                    ADDR_WIDTH  = 32,
  parameter logic [ADDR_WIDTH-1:0] DCCM_BASE   = 32'h2000_0000,
  parameter logic [ADDR_WIDTH-1:0] ICCM_BASE   = 32'h1000_0000,
  parameter int                    WINDOW_BITS = 16
) (
  input  logic [ADDR_WIDTH-1:0] addr_q,
  input  bridge_pkg::hsize_t    size_q,
  input  logic                  write_q,
  output logic                  access_err
);
  import bridge_pkg::*;

  logic in_dccm;
  logic in_iccm;
  logic narrow;
  logic window_err;
  logic size_err;
  logic align_err;

  //////////////////////////////
  // Window decode
  //////////////////////////////

  // Only the bits above the window size take part
  assign in_dccm = addr_q[ADDR_WIDTH-1:WINDOW_BITS] == DCCM_BASE[ADDR_WIDTH-1:WINDOW_BITS];
  assign in_iccm = addr_q[ADDR_WIDTH-1:WINDOW_BITS] == ICCM_BASE[ADDR_WIDTH-1:WINDOW_BITS];

  //////////////////////////////
  // Error terms
  //////////////////////////////

  // Anything below a word
  assign narrow = !(size_q == SZ_WORD || size_q == SZ_DWORD);

  // Outside both memories
  assign window_err = !(in_dccm | in_iccm);

  // ICCM takes words only, DCCM writes likewise
  // narrow DCCM reads are fine
  assign size_err = (in_iccm | (in_dccm & write_q)) & narrow;

  // Natural alignment for half, word and doubleword
  assign align_err = ((size_q == SZ_HALF)  & addr_q[0])
                   | ((size_q == SZ_WORD)  & (|addr_q[1:0]))
                   | ((size_q == SZ_DWORD) & (|addr_q[2:0]));

  assign access_err = window_err | size_err | align_err;

endmodule

/* rtl/ahb_slave/ahb_addr_phase.sv */
// AHB address phase capture
// Registers address, size and direction of each accepted transfer,
// keeps one-cycle copies of htrans, hready and hresp,
// and forms the write byte strobes for the data phase

module ahb_addr_phase #(
  parameter int ADDR_WIDTH = 32
) (
  input  logic                         bus_clk,
  input  logic                         rst_l,
  input  logic                         hsel,
  input  logic [ADDR_WIDTH-1:0]        haddr,
  input  logic                         hwrite,
  input  bridge_pkg::hsize_t           hsize,
  input  bridge_pkg::htrans_t          htrans,
  input  logic                         hreadyout,
  input  logic                         hresp,
  output logic [ADDR_WIDTH-1:0]        addr_q,
  output bridge_pkg::hsize_t           size_q,
  output logic                         write_q,
  output bridge_pkg::htrans_t          trans_q,
  output logic                         hready_q,
  output logic                         hresp_q,
  output logic [bridge_pkg::STRB_W-1:0] wstrb
);
  import bridge_pkg::*;

  logic accept;

  // Bridge is the only slave so its own hreadyout is the bus ready
  assign accept = hsel & (htrans == TR_NONSEQ || htrans == TR_SEQ) & hreadyout;

  // Address phase payload, held for the whole data phase
  always_ff @(posedge bus_clk) begin
    if (accept) begin
      addr_q  <= haddr;
      size_q  <= hsize;
      write_q <= hwrite;
    end
  end

  // Per-cycle copies
  // hready_q and hresp_q detect the second error cycle
  always_ff @(posedge bus_clk or negedge rst_l) begin
    if (!rst_l) begin
      trans_q  <= TR_IDLE;
      hready_q <= 1'b0;
      hresp_q  <= 1'b0;
    end else begin
      // Unselected cycles look idle to the controller
      trans_q  <= hsel ? htrans : TR_IDLE;
      hready_q <= hreadyout;
      hresp_q  <= hresp;
    end
  end

  // Byte lanes from size and low address bits
  always_comb begin
    case (size_q)
      SZ_BYTE:  wstrb = STRB_W'(1)     << addr_q[2:0];
      SZ_HALF:  wstrb = STRB_W'(2'h3)  << addr_q[2:0];
      SZ_WORD:  wstrb = STRB_W'(4'hf)  << addr_q[2:0];
      SZ_DWORD: wstrb = '1;
      default:  wstrb = '0;
    endcase
  end

endmodule

/* common/bridge_pkg.sv */
// AHB-Lite to AXI4 bridge shared definitions
// Bus widths, AHB transfer encodings and controller states
// used across the slave front end and the command buffer

package bridge_pkg;

  //////////////////////////////
  // Bus widths
  //////////////////////////////

  // Data path is fixed at one doubleword
  localparam int DATA_W = 64;
  // One strobe per data byte
  localparam int STRB_W = DATA_W / 8;
  // AXI response code
  localparam int RESP_W = 2;

  //////////////////////////////
  // AHB encodings
  //////////////////////////////

  // htrans values, bit 1 marks an active transfer
  typedef enum logic [1:0] {
    TR_IDLE   = 2'b00,
    TR_BUSY   = 2'b01,
    TR_NONSEQ = 2'b10,
    TR_SEQ    = 2'b11
  } htrans_t;

  // hsize values, shared with axi aw/ar size
  typedef enum logic [2:0] {
    SZ_BYTE  = 3'b000,
    SZ_HALF  = 3'b001,
    SZ_WORD  = 3'b010,
    SZ_DWORD = 3'b011
  } hsize_t;

  //////////////////////////////
  // Controller states
  //////////////////////////////

  typedef enum logic [1:0] {
    // No transfer in its data phase
    ST_IDLE = 2'b00,
    // Write accepted, waiting to load the buffer
    ST_WR   = 2'b01,
    // Read accepted, waiting to load the buffer
    ST_RD   = 2'b10,
    // Read issued, waiting on r_valid
    ST_PEND = 2'b11
  } bridge_state_t;

endpackage
